//--- source/biquad_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types and sizing constants for the two-section IIR cascade
// sample, coefficient, scale, section and field types; FIFO and credit sizes
////////////////////////////////////////////////////////////////////////////
package biquad_pkg;

	////////////////////////////////////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////////////////////////////////////

	// audio samples at the ports
	localparam int SAMPLE_W = 16;
	// 2.16 coefficients and internal filter values
	localparam int COEF_W = 18;
	// output left shift amount
	localparam int SCALE_W = 3;

	// cascaded second order sections
	localparam int NUM_SECTIONS = 2;

	// input FIFO depth, also the sender's starting credits
	localparam int IN_DEPTH = 4;
	localparam int IN_PTR_W = $clog2(IN_DEPTH);
	localparam int IN_CNT_W = $clog2(IN_DEPTH + 1);

	// output FIFO depth and the downstream credits held after reset
	localparam int OUT_DEPTH = 4;
	localparam int OUT_PTR_W = $clog2(OUT_DEPTH);
	localparam int OUT_CNT_W = $clog2(OUT_DEPTH + 1);
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic [SCALE_W-1:0] scale_t;
	typedef logic [0:0] section_idx_t;

	// fifo pointers, occupancy and credit counters
	typedef logic [IN_PTR_W-1:0] in_ptr_t;
	typedef logic [IN_CNT_W-1:0] in_cnt_t;
	typedef logic [OUT_PTR_W-1:0] out_ptr_t;
	typedef logic [OUT_CNT_W-1:0] out_cnt_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	// register hit by a coefficient write
	typedef enum logic [2:0] {
		B1    = 3'd0,
		B2    = 3'd1,
		B3    = 3'd2,
		A2    = 3'd3,
		A3    = 3'd4,
		SCALE = 3'd5
	} coef_field_t;

	// 1.0 in 2.16, b1 after reset
	localparam coef_t COEF_ONE = 18'h10000;

endpackage

//--- source/sample_input.sv
////////////////////////////////////////////////////////////////////////////
// input side: credit-based sample FIFO, one credit returned per pop
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_input (
	input  logic                lr_clk,
	input  logic                reset,
	input  logic                in_valid,
	input  biquad_pkg::sample_t in_sample,
	input  logic                pop,
	output logic                in_credit,
	output biquad_pkg::sample_t fifo_sample,
	output logic                fifo_nonempty
);

	// sample storage
	biquad_pkg::sample_t mem [biquad_pkg::IN_DEPTH];

	biquad_pkg::in_ptr_t wr_ptr;
	biquad_pkg::in_ptr_t rd_ptr;
	biquad_pkg::in_cnt_t count;

	// write side
	always_ff @(posedge lr_clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_sample;
	end

	// pointers, occupancy and the credit pulse
	always_ff @(posedge lr_clk)
	begin
		if (reset)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			// depth is a power of two so pointers wrap on their own
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back for every sample handed to the sections
			in_credit <= pop;
		end
	end

	// head of queue is read combinationally by the issue control
	assign fifo_sample   = mem[rd_ptr];
	assign fifo_nonempty = (count != '0);

	// upstream only sends while holding a credit, so a full FIFO never sees a write
	a_no_overflow: assert property (@(posedge lr_clk) disable iff (reset)
		in_valid |-> (count != biquad_pkg::in_cnt_t'(biquad_pkg::IN_DEPTH)))
		else $error("sample_input: in_valid while input FIFO is full");

endmodule

//--- source/coef_bank.sv
////////////////////////////////////////////////////////////////////////////
// coefficient register bank, one set of b1..a3 and scale per section
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module coef_bank (
	input  logic                      lr_clk,
	input  logic                      reset,
	input  logic                      coef_we,
	input  biquad_pkg::section_idx_t  coef_sel,
	input  biquad_pkg::coef_field_t   coef_field,
	input  biquad_pkg::coef_t         coef_data,
	output biquad_pkg::coef_t         s0_b1,
	output biquad_pkg::coef_t         s0_b2,
	output biquad_pkg::coef_t         s0_b3,
	output biquad_pkg::coef_t         s0_a2,
	output biquad_pkg::coef_t         s0_a3,
	output biquad_pkg::scale_t        s0_scale,
	output biquad_pkg::coef_t         s1_b1,
	output biquad_pkg::coef_t         s1_b2,
	output biquad_pkg::coef_t         s1_b3,
	output biquad_pkg::coef_t         s1_a2,
	output biquad_pkg::coef_t         s1_a3,
	output biquad_pkg::scale_t        s1_scale
);

	// per-section registers, indexed by coef_sel
	biquad_pkg::coef_t  b1_r    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  b2_r    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  b3_r    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  a2_r    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  a3_r    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::scale_t scale_r [biquad_pkg::NUM_SECTIONS];

	always_ff @(posedge lr_clk)
	begin
		if (reset)
		begin
			// identity: y = x through every section
			for (int i = 0; i < biquad_pkg::NUM_SECTIONS; i++)
			begin
				b1_r[i]    <= biquad_pkg::COEF_ONE;
				b2_r[i]    <= '0;
				b3_r[i]    <= '0;
				a2_r[i]    <= '0;
				a3_r[i]    <= '0;
				scale_r[i] <= '0;
			end
		end
		else if (coef_we)
		begin
			case (coef_field)
				biquad_pkg::B1:    b1_r[coef_sel] <= coef_data;
				biquad_pkg::B2:    b2_r[coef_sel] <= coef_data;
				biquad_pkg::B3:    b3_r[coef_sel] <= coef_data;
				biquad_pkg::A2:    a2_r[coef_sel] <= coef_data;
				biquad_pkg::A3:    a3_r[coef_sel] <= coef_data;
				// shift amount lives in the low bits of the data word
				biquad_pkg::SCALE: scale_r[coef_sel] <= coef_data[biquad_pkg::SCALE_W-1:0];
				default:           ;
			endcase
		end
	end

	// section 0
	assign s0_b1    = b1_r[0];
	assign s0_b2    = b2_r[0];
	assign s0_b3    = b3_r[0];
	assign s0_a2    = a2_r[0];
	assign s0_a3    = a3_r[0];
	assign s0_scale = scale_r[0];

	// section 1
	assign s1_b1    = b1_r[1];
	assign s1_b2    = b2_r[1];
	assign s1_b3    = b3_r[1];
	assign s1_a2    = a2_r[1];
	assign s1_a3    = a3_r[1];
	assign s1_scale = scale_r[1];

endmodule

//--- source/biquad_section.sv
////////////////////////////////////////////////////////////////////////////
// second order IIR section, direct form II transposed, 2.16 arithmetic
// history advances and output registers only on a valid input sample
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module biquad_section (
	input  logic                lr_clk,
	input  logic                reset,
	input  logic                in_valid,
	input  biquad_pkg::sample_t in_sample,
	input  biquad_pkg::coef_t   b1,
	input  biquad_pkg::coef_t   b2,
	input  biquad_pkg::coef_t   b3,
	input  biquad_pkg::coef_t   a2,
	input  biquad_pkg::coef_t   a3,
	input  biquad_pkg::scale_t  scale,
	output logic                out_valid,
	output biquad_pkg::sample_t out_sample
);

	// signed 2.16 multiply
	// keeps the sign bit and product bits 32..16, everything else dropped
	function automatic biquad_pkg::coef_t mult_2p16(input biquad_pkg::coef_t a,
			input biquad_pkg::coef_t b);
		logic signed [2*biquad_pkg::COEF_W-1:0] prod;
		prod = a * b;
		return {prod[35], prod[32:16]};
	endfunction

	////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////

	// sample widened to 18 bits, two zero lsbs
	biquad_pkg::coef_t x_ext;

	// feed-forward and feedback products
	biquad_pkg::coef_t b1_x, b2_x, b3_x;
	biquad_pkg::coef_t a2_y, a3_y;

	// history registers and their next values
	biquad_pkg::coef_t f_n1, f_n2;
	biquad_pkg::coef_t f_n1_next, f_n2_next;

	// scaled section output, full 18 bits
	biquad_pkg::coef_t f_n0;

	assign x_ext = {in_sample, 2'b00};

	assign b1_x = mult_2p16(b1, x_ext);
	assign b2_x = mult_2p16(b2, x_ext);
	assign b3_x = mult_2p16(b3, x_ext);

	// sum wraps at 18 bits, so does the shift
	assign f_n0 = (f_n1 + b1_x) << scale;

	// feedback taps come off the scaled output
	assign a2_y = mult_2p16(a2, f_n0);
	assign a3_y = mult_2p16(a3, f_n0);

	assign f_n1_next = b2_x + f_n2 + a2_y;
	assign f_n2_next = b3_x + a3_y;

	////////////////////////////////////////////////////////////////////////
	// state and output registers
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge lr_clk)
	begin
		if (reset)
		begin
			f_n1      <= '0;
			f_n2      <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			// history only moves on a real sample
			if (in_valid)
			begin
				f_n1 <= f_n1_next;
				f_n2 <= f_n2_next;
			end
		end
	end

	// output word, top 16 of the 18 bits
	always_ff @(posedge lr_clk)
	begin
		if (in_valid)
			out_sample <= f_n0[17:2];
	end

endmodule

//--- source/sample_output.sv
////////////////////////////////////////////////////////////////////////////
// output side: sample FIFO gated by a downstream credit counter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_output (
	input  logic                 lr_clk,
	input  logic                 reset,
	input  logic                 push,
	input  biquad_pkg::sample_t  push_sample,
	input  logic                 out_credit,
	output logic                 out_valid,
	output biquad_pkg::sample_t  out_sample,
	output biquad_pkg::out_cnt_t free_slots
);

	biquad_pkg::sample_t mem [biquad_pkg::OUT_DEPTH];

	biquad_pkg::out_ptr_t wr_ptr;
	biquad_pkg::out_ptr_t rd_ptr;
	biquad_pkg::out_cnt_t count;
	biquad_pkg::credit_t  credit_cnt;

	// a sample goes out when one is queued and the receiver has room
	logic send;

	assign send = (count != '0) && (credit_cnt != '0);

	always_ff @(posedge lr_clk)
	begin
		if (push)
			mem[wr_ptr] <= push_sample;
		if (send)
			out_sample <= mem[rd_ptr];
	end

	always_ff @(posedge lr_clk)
	begin
		if (reset)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_cnt <= biquad_pkg::credit_t'(biquad_pkg::OUT_CREDITS);
			out_valid  <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// spend one per send, regain one per returned credit
			case ({out_credit, send})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			out_valid <= send;
		end
	end

	// issue control subtracts its in-flight samples from this
	assign free_slots = biquad_pkg::out_cnt_t'(biquad_pkg::OUT_DEPTH) - count;

	// receiver must never hand back more credits than it was given
	a_credit_limit: assert property (@(posedge lr_clk) disable iff (reset)
		out_credit |-> (credit_cnt != biquad_pkg::credit_t'(biquad_pkg::OUT_CREDITS)) || send)
		else $error("sample_output: credit count would pass OUT_CREDITS");

	a_no_overflow: assert property (@(posedge lr_clk) disable iff (reset)
		push |-> (count != biquad_pkg::out_cnt_t'(biquad_pkg::OUT_DEPTH)))
		else $error("sample_output: push into full output FIFO");

endmodule

//--- source/iir_cascade_top.sv
////////////////////////////////////////////////////////////////////////////
// two-section IIR cascade with credit-based input and output FIFOs
// issue control pops only when the output FIFO can take the sample
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module iir_cascade_top (
	input  logic                     lr_clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  biquad_pkg::sample_t      in_sample,
	output logic                     in_credit,
	input  logic                     coef_we,
	input  biquad_pkg::section_idx_t coef_sel,
	input  biquad_pkg::coef_field_t  coef_field,
	input  biquad_pkg::coef_t        coef_data,
	input  logic                     out_credit,
	output logic                     out_valid,
	output biquad_pkg::sample_t      out_sample
);

	// input FIFO to section 0
	logic                pop;
	logic                fifo_nonempty;
	biquad_pkg::sample_t fifo_sample;
	logic                s0_valid;

	// section 0 to section 1, section 1 to output FIFO
	logic                s1_valid;
	biquad_pkg::sample_t s1_sample;
	logic                s2_valid;
	biquad_pkg::sample_t s2_sample;

	// output room and samples already committed to it
	biquad_pkg::out_cnt_t free_slots;
	biquad_pkg::out_cnt_t inflight_cnt;

	// coefficient busses
	biquad_pkg::coef_t  s0_b1, s0_b2, s0_b3, s0_a2, s0_a3;
	biquad_pkg::coef_t  s1_b1, s1_b2, s1_b3, s1_a2, s1_a3;
	biquad_pkg::scale_t s0_scale, s1_scale;

	////////////////////////////////////////////////////////////////////////
	// issue control
	////////////////////////////////////////////////////////////////////////

	// pop only if a slot is left after the samples still in the sections
	assign pop      = fifo_nonempty && (free_slots > inflight_cnt);
	assign s0_valid = pop;

	// in flight from pop until the write into the output FIFO
	always_ff @(posedge lr_clk)
	begin
		if (reset)
			inflight_cnt <= '0;
		else
		begin
			case ({pop, s2_valid})
				2'b10:   inflight_cnt <= inflight_cnt + 1'b1;
				2'b01:   inflight_cnt <= inflight_cnt - 1'b1;
				default: inflight_cnt <= inflight_cnt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////

	sample_input input_i (
		.lr_clk        (lr_clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_sample     (in_sample),
		.pop           (pop),
		.in_credit     (in_credit),
		.fifo_sample   (fifo_sample),
		.fifo_nonempty (fifo_nonempty)
	);

	coef_bank coef_i (
		.lr_clk     (lr_clk),
		.reset      (reset),
		.coef_we    (coef_we),
		.coef_sel   (coef_sel),
		.coef_field (coef_field),
		.coef_data  (coef_data),
		.s0_b1      (s0_b1),
		.s0_b2      (s0_b2),
		.s0_b3      (s0_b3),
		.s0_a2      (s0_a2),
		.s0_a3      (s0_a3),
		.s0_scale   (s0_scale),
		.s1_b1      (s1_b1),
		.s1_b2      (s1_b2),
		.s1_b3      (s1_b3),
		.s1_a2      (s1_a2),
		.s1_a3      (s1_a3),
		.s1_scale   (s1_scale)
	);

	biquad_section section0_i (
		.lr_clk     (lr_clk),
		.reset      (reset),
		.in_valid   (s0_valid),
		.in_sample  (fifo_sample),
		.b1         (s0_b1),
		.b2         (s0_b2),
		.b3         (s0_b3),
		.a2         (s0_a2),
		.a3         (s0_a3),
		.scale      (s0_scale),
		.out_valid  (s1_valid),
		.out_sample (s1_sample)
	);

	biquad_section section1_i (
		.lr_clk     (lr_clk),
		.reset      (reset),
		.in_valid   (s1_valid),
		.in_sample  (s1_sample),
		.b1         (s1_b1),
		.b2         (s1_b2),
		.b3         (s1_b3),
		.a2         (s1_a2),
		.a3         (s1_a3),
		.scale      (s1_scale),
		.out_valid  (s2_valid),
		.out_sample (s2_sample)
	);

	sample_output output_i (
		.lr_clk      (lr_clk),
		.reset       (reset),
		.push        (s2_valid),
		.push_sample (s2_sample),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_sample  (out_sample),
		.free_slots  (free_slots)
	);

endmodule

//--- tb/iir_cascade_checker.sv
////////////////////////////////////////////////////////////////////////////
// bit-exact reference model of the two-section cascade
// watches the DUT ports, compares every output, keeps per-test counts
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module iir_cascade_checker (
	input logic                     lr_clk,
	input logic                     reset,
	input logic                     in_valid,
	input biquad_pkg::sample_t      in_sample,
	input logic                     in_credit,
	input logic                     coef_we,
	input biquad_pkg::section_idx_t coef_sel,
	input biquad_pkg::coef_field_t  coef_field,
	input biquad_pkg::coef_t        coef_data,
	input logic                     out_credit,
	input logic                     out_valid,
	input biquad_pkg::sample_t      out_sample
);

	// accepted samples not yet seen at the output
	biquad_pkg::sample_t in_q [$];

	// model coefficients and history per section
	biquad_pkg::coef_t  m_b1    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_b2    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_b3    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_a2    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_a3    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::scale_t m_scale [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_h1    [biquad_pkg::NUM_SECTIONS];
	biquad_pkg::coef_t  m_h2    [biquad_pkg::NUM_SECTIONS];

	biquad_pkg::sample_t expected;

	// sender credits left and receiver credits owed as seen at the ports
	int in_credits = biquad_pkg::IN_DEPTH;
	int owed = 0;

	// run totals
	int test_cnt = 0;
	int check_cnt = 0;
	int error_cnt = 0;

	// per-test counts that start_test clears
	int t_checks = 0;
	int t_errors = 0;
	int t_out = 0;
	int t_accept = 0;
	int t_credit = 0;

	// 2.16 product with the sign bit on top of product bits 32..16
	function automatic biquad_pkg::coef_t fixmul(input biquad_pkg::coef_t a,
			input biquad_pkg::coef_t b);
		logic signed [35:0] p;
		p = a * b;
		return {p[35], p[32:16]};
	endfunction

	// one sample through model section s and its history
	function automatic biquad_pkg::sample_t run_section(input int s,
			input biquad_pkg::sample_t x);
		biquad_pkg::coef_t xe;
		biquad_pkg::coef_t y;
		xe = {x, 2'b00};
		// 18-bit sum and 18-bit shift both wrap
		y = (m_h1[s] + fixmul(m_b1[s], xe)) << m_scale[s];
		m_h1[s] = fixmul(m_b2[s], xe) + m_h2[s] + fixmul(m_a2[s], y);
		m_h2[s] = fixmul(m_b3[s], xe) + fixmul(m_a3[s], y);
		return y[17:2];
	endfunction

	// identity coefficients, cleared history, empty queue
	task automatic reset_model();
		for (int s = 0; s < biquad_pkg::NUM_SECTIONS; s++)
		begin
			m_b1[s] = biquad_pkg::COEF_ONE;
			m_b2[s] = '0;
			m_b3[s] = '0;
			m_a2[s] = '0;
			m_a3[s] = '0;
			m_scale[s] = '0;
			m_h1[s] = '0;
			m_h2[s] = '0;
		end
		in_q.delete();
		in_credits = biquad_pkg::IN_DEPTH;
		owed = 0;
	endtask

	task automatic flag(input string msg);
		$display("%s", msg);
		error_cnt++;
		t_errors++;
	endtask

	function automatic int pending();
		return in_q.size();
	endfunction

	////////////////////////////////////////////////////////////////////////
	// test bookkeeping for the testbench top
	////////////////////////////////////////////////////////////////////////

	task automatic start_test();
		t_checks = 0;
		t_errors = 0;
		t_out = 0;
		t_accept = 0;
		t_credit = 0;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("test %0d (%s): %0d outputs checked, %0d errors",
			test_cnt, name, t_checks, t_errors);
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
			flag($sformatf("%s: counted %0d, expected %0d", what, got, exp));
	endtask

	task automatic report();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
	endtask

	////////////////////////////////////////////////////////////////////////
	// port monitor
	////////////////////////////////////////////////////////////////////////

	always @(posedge lr_clk)
	begin
		if (reset)
			reset_model();
		else
		begin
			// coefficient writes only happen while the cascade is idle
			if (coef_we)
			begin
				case (coef_field)
					biquad_pkg::B1:    m_b1[coef_sel] = coef_data;
					biquad_pkg::B2:    m_b2[coef_sel] = coef_data;
					biquad_pkg::B3:    m_b3[coef_sel] = coef_data;
					biquad_pkg::A2:    m_a2[coef_sel] = coef_data;
					biquad_pkg::A3:    m_a3[coef_sel] = coef_data;
					biquad_pkg::SCALE: m_scale[coef_sel] = coef_data[2:0];
					default:           ;
				endcase
			end
			if (in_valid)
			begin
				if (in_credits == 0)
					flag("in_valid arrived while the sender held no credit");
				in_credits--;
				in_q.push_back(in_sample);
				t_accept++;
			end
			if (in_credit)
			begin
				in_credits++;
				t_credit++;
				// a credit can only come back for a sample the DUT has taken
				if (in_credits > biquad_pkg::IN_DEPTH)
					flag("in_credit returned a credit for a sample never taken");
			end
			if (out_valid)
			begin
				// the DUT may only send while it holds a downstream credit
				if (owed >= biquad_pkg::OUT_CREDITS)
					flag("out_valid sent while the DUT held no downstream credit");
				owed++;
				t_out++;
				if (in_q.size() == 0)
					flag("out_valid with no accepted sample pending");
				else
				begin
					// both sections in order with their own history
					expected = run_section(1, run_section(0, in_q.pop_front()));
					check_cnt++;
					t_checks++;
					if (out_sample !== expected)
						flag($sformatf("Mismatch out_sample: got %h, expected %h",
							out_sample, expected));
				end
			end
			// receiver hands credits back one at a time
			if (out_credit)
				owed--;
		end
	end

endmodule

//--- tb/iir_cascade_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench top: clock, reset, seeded random traffic, coefficient loads
// and the test sequence for the IIR cascade
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module iir_cascade_tb;

	logic                     lr_clk;
	logic                     reset;
	logic                     in_valid;
	biquad_pkg::sample_t      in_sample;
	logic                     in_credit;
	logic                     coef_we;
	biquad_pkg::section_idx_t coef_sel;
	biquad_pkg::coef_field_t  coef_field;
	biquad_pkg::coef_t        coef_data;
	logic                     out_credit;
	logic                     out_valid;
	biquad_pkg::sample_t      out_sample;

	int seed;
	// samples still to send, sender credits, receiver credits owed
	int send_left;
	int in_credits;
	int owed;
	// credit return on or off, impulse stimulus instead of random
	bit credits_on;
	bit impulse_mode;
	bit impulse_sent;
	bit timed_out;

	initial lr_clk = 1'b0;
	always #20 lr_clk = ~lr_clk;

	iir_cascade_top iir_cascade_top_i (
		.lr_clk     (lr_clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_credit  (in_credit),
		.coef_we    (coef_we),
		.coef_sel   (coef_sel),
		.coef_field (coef_field),
		.coef_data  (coef_data),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_sample (out_sample)
	);

	iir_cascade_checker checker_i (
		.lr_clk     (lr_clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_credit  (in_credit),
		.coef_we    (coef_we),
		.coef_sel   (coef_sel),
		.coef_field (coef_field),
		.coef_data  (coef_data),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_sample (out_sample)
	);

	// credits come back on the sampling edge
	always @(posedge lr_clk)
	begin
		if (reset)
		begin
			in_credits = biquad_pkg::IN_DEPTH;
			owed = 0;
		end
		else
		begin
			if (in_credit)
				in_credits++;
			if (out_valid)
				owed++;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// stimulus tasks, all driving on the falling edge
	////////////////////////////////////////////////////////////////////////

	// one cycle of sender and receiver traffic
	task automatic step();
		@(negedge lr_clk);
		in_valid = 1'b0;
		out_credit = 1'b0;
		// send only while holding a credit
		if (send_left > 0 && in_credits > 0 && ($random(seed) & 3) != 0)
		begin
			in_valid = 1'b1;
			if (impulse_mode)
				in_sample = impulse_sent ? 16'h0000 : 16'h4000;
			else
				in_sample = $random(seed);
			impulse_sent = 1'b1;
			send_left--;
			in_credits--;
		end
		if (credits_on && owed > 0 && ($random(seed) & 1))
		begin
			out_credit = 1'b1;
			owed--;
		end
	endtask

	// traffic over a bounded window, used to let back-pressure settle
	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++)
			step();
	endtask

	// traffic until every sample is sent, received and credited back
	task automatic drain(input string what);
		int t;
		if (timed_out)
			return;
		for (t = 0; t < 4000; t++)
		begin
			step();
			if (send_left == 0 && !in_valid && owed == 0 && checker_i.pending() == 0)
				break;
		end
		if (t == 4000)
		begin
			$display("timeout while draining %s, samples never came out", what);
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		in_valid = 1'b0;
		out_credit = 1'b0;
		coef_we = 1'b0;
		repeat (3) @(negedge lr_clk);
		reset = 1'b0;
	endtask

	task automatic write_coef(input biquad_pkg::section_idx_t sel,
			input biquad_pkg::coef_field_t field, input biquad_pkg::coef_t data);
		@(negedge lr_clk);
		in_valid = 1'b0;
		out_credit = 1'b0;
		coef_we = 1'b1;
		coef_sel = sel;
		coef_field = field;
		coef_data = data;
		@(negedge lr_clk);
		coef_we = 1'b0;
	endtask

	// random taps over the full 2.16 range, given shift
	task automatic load_section(input biquad_pkg::section_idx_t sel,
			input biquad_pkg::scale_t sc);
		write_coef(sel, biquad_pkg::B1, $random(seed));
		write_coef(sel, biquad_pkg::B2, $random(seed));
		write_coef(sel, biquad_pkg::B3, $random(seed));
		write_coef(sel, biquad_pkg::A2, $random(seed));
		write_coef(sel, biquad_pkg::A3, $random(seed));
		write_coef(sel, biquad_pkg::SCALE, biquad_pkg::coef_t'(sc));
	endtask

	////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h61e9f68e;
		in_sample = '0;
		coef_sel = '0;
		coef_field = biquad_pkg::B1;
		coef_data = '0;
		send_left = 0;
		in_credits = biquad_pkg::IN_DEPTH;
		owed = 0;
		credits_on = 1'b1;
		impulse_mode = 1'b0;
		impulse_sent = 1'b0;
		timed_out = 1'b0;
		apply_reset();

		checker_i.start_test();
		send_left = 40;
		drain("identity");
		checker_i.end_test("identity after reset");

		load_section(0, 3'd0);
		checker_i.start_test();
		send_left = 40;
		drain("single section");
		checker_i.end_test("single section filtering");

		load_section(0, biquad_pkg::scale_t'({$random(seed)} % 7 + 1));
		load_section(1, biquad_pkg::scale_t'({$random(seed)} % 7 + 1));
		checker_i.start_test();
		send_left = 60;
		drain("cascade");
		checker_i.end_test("full cascade with scale");

		// with no credits back only the reset credits can be spent
		checker_i.start_test();
		credits_on = 1'b0;
		send_left = 16;
		run_cycles(100);
		checker_i.check_count("out_valid pulses while credits were withheld",
			checker_i.t_out, biquad_pkg::OUT_CREDITS);
		credits_on = 1'b1;
		drain("back-pressure");
		checker_i.end_test("output back-pressure");

		checker_i.start_test();
		send_left = 50;
		drain("input credits");
		checker_i.check_count("in_credit pulses against samples accepted",
			checker_i.t_credit, checker_i.t_accept);
		checker_i.check_count("samples accepted", checker_i.t_accept, 50);
		checker_i.end_test("input credits");

		// reset with samples still inside, then an impulse into a fresh cascade
		checker_i.start_test();
		send_left = 30;
		run_cycles(15);
		apply_reset();
		impulse_mode = 1'b1;
		impulse_sent = 1'b0;
		send_left = 12;
		drain("impulse after reset");
		checker_i.end_test("reset mid-stream");

		checker_i.report();
		if (timed_out || checker_i.error_cnt != 0)
			$display("tests failed");
		else
			$display("all tests passed");
		$finish;
	end

endmodule

//--- files.f
source/biquad_pkg.sv
source/sample_input.sv
source/coef_bank.sv
source/biquad_section.sv
source/sample_output.sv
source/iir_cascade_top.sv
tb/iir_cascade_checker.sv
tb/iir_cascade_tb.sv
